//--- compile.f
hw/hpm_cfg_pkg.sv
hw/hpm_event_pkg.sv
hw/hpm_counter.sv
hw/hpm_counter_bank.sv
hw/hpm_csr_port.sv
hw/hpm_unit.sv
dv/hpm_unit_asserts.sv
dv/hpm_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the hpm unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=obj_dir/hpm_unit_sim

verilator --binary --timing --assert -Wno-fatal \
    --top-module hpm_unit_tb -f compile.f -o hpm_unit_sim
if [ $? -ne 0 ]; then
    echo "run_sim: verilator build failed"
    exit 1
fi

"$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "run_sim: simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
    exit 0
fi
echo "run_sim: pass message not found in $LOG"
exit 1

//--- dv/hpm_unit_tb.sv
// hpm unit testbench
`timescale 1ns/1ps
`default_nettype none

module hpm_unit_tb
    import hpm_cfg_pkg::*;
    import hpm_event_pkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 10;
    localparam int RESET_CYCLES = 2;
    localparam int STREAM_LEN   = 150;   // random event cycles per stream
    localparam int MAX_OPS      = 220;   // csr accesses over all tests, rounded up
    localparam int OP_CYCLES    = 3;     // worst case per access
    localparam int READ_WAIT    = 4;
    localparam int TEST_CYCLES  = RESET_CYCLES + 2 * (STREAM_LEN + 3) + MAX_OPS * OP_CYCLES;

    logic                      clk_i;
    logic                      rstn_i;
    core_evt_t                 core_evt;
    mem_evt_t                  mem_evt;
    priv_lvl_t                 priv_lvl;
    logic [CSR_ADDR_WIDTH-1:0] csr_addr;
    logic                      csr_we;
    logic [XLEN-1:0]           csr_wdata;
    logic                      csr_rd;
    logic [XLEN-1:0]           csr_rdata;
    logic                      csr_rvalid;
    logic                      ovf_irq;

    // reference state
    logic [XLEN-1:0]           m_cnt [HPM_NUM_COUNTERS];
    logic [XLEN-1:0]           m_sel [HPM_NUM_COUNTERS];
    logic [31:0]               m_inh;
    logic [HPM_NUM_EVENTS:1]   m_evt;     // registered events
    priv_lvl_t                 m_priv;
    logic [XLEN-1:0]           exp_q [$]; // pending read results
    logic [31:0]               rng;
    int                        data_errors  = 0;
    int                        proto_errors = 0;
    int                        reads_done   = 0;

    hpm_unit dut (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .core_evt_i   (core_evt),
        .mem_evt_i    (mem_evt),
        .priv_lvl_i   (priv_lvl),
        .csr_addr_i   (csr_addr),
        .csr_we_i     (csr_we),
        .csr_wdata_i  (csr_wdata),
        .csr_rd_i     (csr_rd),
        .csr_rdata_o  (csr_rdata),
        .csr_rvalid_o (csr_rvalid),
        .ovf_irq_o    (ovf_irq)
    );

    bind hpm_unit hpm_unit_asserts u_asserts (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .csr_addr_i   (csr_addr_i),
        .csr_rd_i     (csr_rd_i),
        .csr_rvalid_i (csr_rvalid_o),
        .csr_rdata_i  (csr_rdata_o),
        .ovf_irq_i    (ovf_irq_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // --------------------------------------------------
    // reference functions
    // --------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // selector word: inhibits in 62..60, event index in 4..0
    function automatic logic [XLEN-1:0] sel_word(input logic minh, input logic sinh,
                                                 input logic uinh, input logic [4:0] idx);
        logic [XLEN-1:0] w;
        w      = '0;
        w[62]  = minh;
        w[61]  = sinh;
        w[60]  = uinh;
        w[4:0] = idx;
        return w;
    endfunction

    // count after one edge, from registered events and privilege
    function automatic logic [XLEN-1:0] next_count(input logic [XLEN-1:0] cnt,
            input logic [HPM_NUM_EVENTS:1] evt, input priv_lvl_t priv,
            input logic [XLEN-1:0] sel, input logic inh);
        int   idx;
        logic blocked;
        idx = int'(sel[4:0]);
        case (priv)
            PRIV_U:  blocked = sel[60];
            PRIV_S:  blocked = sel[61];
            PRIV_M:  blocked = sel[62];
            default: blocked = 1'b0;
        endcase
        if (inh || blocked || idx == 0 || idx > HPM_NUM_EVENTS) begin
            return cnt;                           // index 0 never counts
        end
        return evt[idx] ? cnt + 64'd1 : cnt;
    endfunction

    function automatic logic [XLEN-1:0] expected_read(input logic [CSR_ADDR_WIDTH-1:0] addr);
        logic [XLEN-1:0] v;
        v = '0;                                   // unmapped reads zero
        for (int i = 0; i < HPM_NUM_COUNTERS; i++) begin
            if (addr == MHPMCOUNTER_BASE + CSR_ADDR_WIDTH'(i)) v = m_cnt[i];
            if (addr == MHPMEVENT_BASE + CSR_ADDR_WIDTH'(i)) v = m_sel[i];
            if (addr == SCOUNTOVF_ADDR) v[HPM_FIRST_CNT + i] = m_sel[i][63];
        end
        if (addr == MCOUNTINHIBIT_ADDR) v = {32'd0, m_inh};
        return v;
    endfunction

    // --------------------------------------------------
    // model, updated at each edge from the sampled inputs
    // --------------------------------------------------
    always @(posedge clk_i) begin
        logic [XLEN-1:0] nxt;
        logic            cnt_wr;
        if (!rstn_i) begin
            for (int i = 0; i < HPM_NUM_COUNTERS; i++) begin
                m_cnt[i] = '0;
                m_sel[i] = '0;
            end
            m_inh  = '0;
            m_evt  = '0;
            m_priv = PRIV_M;
        end else begin
            if (csr_rd) exp_q.push_back(expected_read(csr_addr));  // state before the edge
            for (int i = 0; i < HPM_NUM_COUNTERS; i++) begin
                nxt    = next_count(m_cnt[i], m_evt, m_priv, m_sel[i], m_inh[HPM_FIRST_CNT + i]);
                cnt_wr = csr_we && (csr_addr == MHPMCOUNTER_BASE + CSR_ADDR_WIDTH'(i));
                if (csr_we && csr_addr == MHPMEVENT_BASE + CSR_ADDR_WIDTH'(i)) begin
                    m_sel[i] = csr_wdata;
                end else if (!cnt_wr && m_cnt[i] == '1 && nxt == '0) begin
                    m_sel[i][63] = 1'b1;          // wrap sets the sticky bit
                end
                m_cnt[i] = cnt_wr ? csr_wdata : nxt;
            end
            if (csr_we && csr_addr == MCOUNTINHIBIT_ADDR) m_inh = csr_wdata[31:0];
            for (int j = 0; j < 8; j++) begin
                m_evt[1 + j] = core_evt[7 - j];   // first struct field is event 1
                m_evt[9 + j] = mem_evt[7 - j];
            end
            m_priv = priv_lvl;
        end
    end

    // compare at the falling edge, where outputs are stable
    always @(negedge clk_i) begin
        logic [XLEN-1:0] want;
        logic            irq_want;
        if (rstn_i) begin
            if (csr_rvalid) begin
                if (exp_q.size() == 0) begin
                    proto_errors++;
                    $display("Error at %0t: csr_rvalid_o high with no read pending", $time);
                end else begin
                    want = exp_q.pop_front();
                    reads_done++;
                    if (csr_rdata !== want) begin
                        data_errors++;
                        $display("Error at %0t: csr_rdata_o = %h, expected %h",
                                 $time, csr_rdata, want);
                    end
                end
            end
            irq_want = 1'b0;
            for (int i = 0; i < HPM_NUM_COUNTERS; i++) irq_want = irq_want | m_sel[i][63];
            if (ovf_irq !== irq_want) begin
                data_errors++;
                $display("Error at %0t: ovf_irq_o = %b, expected %b", $time, ovf_irq, irq_want);
            end
        end
    end

    // --------------------------------------------------
    // stimulus tasks
    // --------------------------------------------------
    task automatic tick();
        @(posedge clk_i);
        #(DRIVE_DELAY);
    endtask

    task automatic csr_write(input logic [CSR_ADDR_WIDTH-1:0] addr, input logic [XLEN-1:0] data);
        csr_addr  = addr;
        csr_wdata = data;
        csr_we    = 1'b1;
        tick();
        csr_we    = 1'b0;
    endtask

    task automatic csr_read(input logic [CSR_ADDR_WIDTH-1:0] addr);
        int waited;
        csr_addr = addr;
        csr_rd   = 1'b1;
        tick();
        csr_rd   = 1'b0;
        waited   = 0;
        while (exp_q.size() != 0 && waited < READ_WAIT) begin
            tick();
            waited++;
        end
        if (exp_q.size() != 0) begin
            proto_errors++;
            $display("Error at %0t: no read response for address %h", $time, addr);
            exp_q.delete();
        end
    endtask

    task automatic read_all();
        for (int i = 0; i < HPM_NUM_COUNTERS; i++) begin
            csr_read(MHPMCOUNTER_BASE + CSR_ADDR_WIDTH'(i));
            csr_read(MHPMEVENT_BASE + CSR_ADDR_WIDTH'(i));
        end
        csr_read(MCOUNTINHIBIT_ADDR);
        csr_read(SCOUNTOVF_ADDR);
    endtask

    task automatic run_events(input int cycles, input logic walk_priv);
        for (int c = 0; c < cycles; c++) begin
            rng      = xorshift32(rng);
            core_evt = core_evt_t'(rng[7:0]);
            mem_evt  = mem_evt_t'(rng[15:8]);
            if (walk_priv) begin
                case (c % 3)
                    0:       priv_lvl = PRIV_U;
                    1:       priv_lvl = PRIV_S;
                    default: priv_lvl = PRIV_M;
                endcase
            end
            tick();
        end
        core_evt = '0;
        mem_evt  = '0;
        tick();
        tick();                                   // let the event stage drain
    endtask

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin
        rng       = 32'h373f1f49;
        rstn_i    = 1'b0;
        core_evt  = '0;
        mem_evt   = '0;
        priv_lvl  = PRIV_M;
        csr_addr  = '0;
        csr_we    = 1'b0;
        csr_wdata = '0;
        csr_rd    = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #(DRIVE_DELAY);
        rstn_i = 1'b1;

        // reset values
        if (ovf_irq !== 1'b0) begin
            data_errors++;
            $display("Error at %0t: ovf_irq_o = %b, expected 0", $time, ovf_irq);
        end
        read_all();

        // write and read back, summary and unmapped writes dropped
        for (int i = 0; i < HPM_NUM_COUNTERS; i++) begin
            rng = xorshift32(rng);
            csr_write(MHPMCOUNTER_BASE + CSR_ADDR_WIDTH'(i), {rng, xorshift32(rng)});
            rng = xorshift32(rng);
            csr_write(MHPMEVENT_BASE + CSR_ADDR_WIDTH'(i), {rng, ~rng});
        end
        csr_write(MCOUNTINHIBIT_ADDR, 64'hFFFF_0000_A5C3_3C5A);
        csr_write(SCOUNTOVF_ADDR, '1);
        csr_write(12'h7C0, '1);
        read_all();
        csr_read(12'h7C0);
        csr_read(MHPMCOUNTER_BASE + CSR_ADDR_WIDTH'(HPM_NUM_COUNTERS));  // one past the bank
        csr_read(MHPMEVENT_BASE - 12'd1);

        // one event index per counter, counter 0 selects nothing
        csr_write(MCOUNTINHIBIT_ADDR, '0);
        for (int i = 0; i < HPM_NUM_COUNTERS; i++) begin
            csr_write(MHPMCOUNTER_BASE + CSR_ADDR_WIDTH'(i), '0);
            csr_write(MHPMEVENT_BASE + CSR_ADDR_WIDTH'(i),
                      sel_word(1'b0, 1'b0, 1'b0, (i == 0) ? 5'd0 : 5'(2 * i + 2)));
        end
        run_events(STREAM_LEN, 1'b0);
        read_all();

        // global and per-privilege inhibits, privilege walks U, S, M
        csr_write(MCOUNTINHIBIT_ADDR, 64'h8000_0019);  // arch 3 and 4 held
        for (int i = 0; i < HPM_NUM_COUNTERS; i++) begin
            csr_write(MHPMCOUNTER_BASE + CSR_ADDR_WIDTH'(i), 64'h100 + 64'(i));
            csr_write(MHPMEVENT_BASE + CSR_ADDR_WIDTH'(i),
                      sel_word(i == 4 || i == 5 || i == 7, i == 3 || i == 5,
                               i == 2 || i == 5 || i == 7, 5'(2 * i + 1)));
        end
        run_events(STREAM_LEN, 1'b1);
        read_all();

        // wrap from all ones on event 1
        priv_lvl = PRIV_M;
        csr_write(MCOUNTINHIBIT_ADDR, '0);
        for (int i = 0; i < HPM_NUM_COUNTERS; i++) begin
            csr_write(MHPMEVENT_BASE + CSR_ADDR_WIDTH'(i),
                      sel_word(1'b0, 1'b0, 1'b0, (i == 0) ? 5'd1 : 5'd0));
        end
        csr_write(MHPMCOUNTER_BASE, '1);
        core_evt.branch_miss = 1'b1;
        tick();
        core_evt = '0;
        tick();
        tick();
        if (ovf_irq !== 1'b1) begin
            data_errors++;
            $display("Error at %0t: ovf_irq_o = %b, expected 1", $time, ovf_irq);
        end
        csr_read(MHPMCOUNTER_BASE);
        csr_read(MHPMEVENT_BASE);
        csr_read(SCOUNTOVF_ADDR);
        csr_write(MHPMEVENT_BASE, sel_word(1'b0, 1'b0, 1'b0, 5'd1));  // clears the sticky bit
        tick();
        if (ovf_irq !== 1'b0) begin
            data_errors++;
            $display("Error at %0t: ovf_irq_o = %b, expected 0", $time, ovf_irq);
        end
        csr_read(MHPMEVENT_BASE);
        csr_read(SCOUNTOVF_ADDR);

        repeat (4) tick();
        if (exp_q.size() != 0) begin
            proto_errors++;
            $display("Error at %0t: reads still pending at the end of the run", $time);
        end
        $display("Reads compared: %0d, data errors: %0d, protocol errors: %0d",
                 reads_done, data_errors, proto_errors);
        if (data_errors == 0 && proto_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        #((TEST_CYCLES + 200) * CLK_PERIOD);
        $display("Error at %0t: watchdog expired, the test sequence did not finish", $time);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/hpm_unit_asserts.sv
// hpm unit port assertions
`timescale 1ns/1ps
`default_nettype none

module hpm_unit_asserts
    import hpm_cfg_pkg::*;
(
    input wire logic                        clk_i,
    input wire logic                        rstn_i,
    input wire logic [CSR_ADDR_WIDTH-1:0]   csr_addr_i,
    input wire logic                        csr_rd_i,
    input wire logic                        csr_rvalid_i,  // dut csr_rvalid_o
    input wire logic [XLEN-1:0]             csr_rdata_i,   // dut csr_rdata_o
    input wire logic                        ovf_irq_i      // dut ovf_irq_o
);

    // --------------------------------------------------
    // read strobe to valid pulse
    // --------------------------------------------------
    rd_then_valid: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        csr_rd_i |=> csr_rvalid_i
    ) else $error("csr_rvalid_o missing one cycle after csr_rd_i");

    // no valid without a read one cycle earlier
    valid_has_rd: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        csr_rvalid_i |-> $past(csr_rd_i)
    ) else $error("csr_rvalid_o high without a read in the cycle before");

    rdata_known: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        csr_rvalid_i |-> !$isunknown(csr_rdata_i)
    ) else $error("csr_rdata_o has unknown bits while csr_rvalid_o is high");

    // --------------------------------------------------
    // interrupt level tracks the sticky bits
    // --------------------------------------------------
    // summary read returns the sticky bits as they were at the read edge
    irq_matches_ovf: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        csr_rvalid_i && ($past(csr_addr_i) == SCOUNTOVF_ADDR)
            |-> ((|csr_rdata_i) == $past(ovf_irq_i))
    ) else $error("ovf_irq_o disagrees with the overflow summary read");

endmodule

`default_nettype wire

//--- hw/hpm_unit.sv
// hardware performance monitor top
`timescale 1ns/1ps
`default_nettype none

module hpm_unit
    import hpm_cfg_pkg::*;
    import hpm_event_pkg::*;
(
    input  wire logic                      clk_i,
    input  wire logic                      rstn_i,
    // event sources, levels
    input  wire core_evt_t                 core_evt_i,
    input  wire mem_evt_t                  mem_evt_i,
    input  wire priv_lvl_t                 priv_lvl_i,
    // --------------------------------------------------
    // csr access
    input  wire logic [CSR_ADDR_WIDTH-1:0] csr_addr_i,
    input  wire logic                      csr_we_i,
    input  wire logic [XLEN-1:0]           csr_wdata_i,
    input  wire logic                      csr_rd_i,
    output logic [XLEN-1:0]                csr_rdata_o,
    output logic                           csr_rvalid_o,
    // overflow interrupt request, level
    output logic                           ovf_irq_o
);

    logic [HPM_NUM_COUNTERS-1:0] cnt_we;
    logic [HPM_NUM_COUNTERS-1:0] sel_we;
    logic [HPM_NUM_COUNTERS-1:0] mcountinhibit;  // programmable counter bits only
    logic [HPM_NUM_COUNTERS-1:0] ovf_bits;
    hpm_csr_word_u               wdata;
    hpm_csr_word_u               cnt_val [HPM_NUM_COUNTERS];
    hpm_csr_word_u               sel_val [HPM_NUM_COUNTERS];

    hpm_csr_port u_csr_port (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .csr_addr_i      (csr_addr_i),
        .csr_we_i        (csr_we_i),
        .csr_wdata_i     (csr_wdata_i),
        .csr_rd_i        (csr_rd_i),
        .csr_rdata_o     (csr_rdata_o),
        .csr_rvalid_o    (csr_rvalid_o),
        .cnt_val_i       (cnt_val),
        .sel_val_i       (sel_val),
        .ovf_bits_i      (ovf_bits),
        .cnt_we_o        (cnt_we),
        .sel_we_o        (sel_we),
        .wdata_o         (wdata),
        .mcountinhibit_o (mcountinhibit)
    );

    hpm_counter_bank u_counter_bank (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .core_evt_i      (core_evt_i),
        .mem_evt_i       (mem_evt_i),
        .priv_lvl_i      (priv_lvl_i),
        .mcountinhibit_i (mcountinhibit),
        .cnt_we_i        (cnt_we),
        .sel_we_i        (sel_we),
        .wdata_i         (wdata),
        .cnt_val_o       (cnt_val),
        .sel_val_o       (sel_val),
        .ovf_bits_o      (ovf_bits),
        .ovf_irq_o       (ovf_irq_o)
    );

endmodule

`default_nettype wire

//--- hw/hpm_csr_port.sv
// hpm csr access port
`timescale 1ns/1ps
`default_nettype none

module hpm_csr_port
    import hpm_cfg_pkg::*;
(
    input  wire logic                        clk_i,
    input  wire logic                        rstn_i,
    input  wire logic [CSR_ADDR_WIDTH-1:0]   csr_addr_i,
    input  wire logic                        csr_we_i,      // level, sampled every edge
    input  wire logic [XLEN-1:0]             csr_wdata_i,
    input  wire logic                        csr_rd_i,      // one-cycle pulse
    output logic [XLEN-1:0]                  csr_rdata_o,
    output logic                             csr_rvalid_o,
    input  wire hpm_csr_word_u               cnt_val_i [HPM_NUM_COUNTERS],
    input  wire hpm_csr_word_u               sel_val_i [HPM_NUM_COUNTERS],
    input  wire logic [HPM_NUM_COUNTERS-1:0] ovf_bits_i,
    output logic [HPM_NUM_COUNTERS-1:0]      cnt_we_o,
    output logic [HPM_NUM_COUNTERS-1:0]      sel_we_o,
    output hpm_csr_word_u                    wdata_o,
    output logic [HPM_NUM_COUNTERS-1:0]      mcountinhibit_o
);

    logic [CSR_ADDR_WIDTH-1:0]      cnt_off;
    logic [CSR_ADDR_WIDTH-1:0]      sel_off;
    logic [CNT_IDX_WIDTH-1:0]       cnt_idx;
    logic [CNT_IDX_WIDTH-1:0]       sel_idx;
    logic                           cnt_hit;
    logic                           sel_hit;
    logic                           inh_hit;
    logic                           ovf_hit;
    logic [MCOUNTINHIBIT_WIDTH-1:0] mcountinhibit_q;
    logic [XLEN-1:0]                ovf_summary;
    logic [XLEN-1:0]                rd_mux;
    logic [XLEN-1:0]                rdata_q;
    logic                           rvalid_q;

    // --------------------------------------------------
    // address decode
    // --------------------------------------------------
    // unsigned offsets wrap below the base, so one compare covers both ends
    assign cnt_off = csr_addr_i - MHPMCOUNTER_BASE;
    assign sel_off = csr_addr_i - MHPMEVENT_BASE;
    assign cnt_hit = cnt_off < CSR_ADDR_WIDTH'(HPM_NUM_COUNTERS);
    assign sel_hit = sel_off < CSR_ADDR_WIDTH'(HPM_NUM_COUNTERS);
    assign cnt_idx = cnt_off[CNT_IDX_WIDTH-1:0];
    assign sel_idx = sel_off[CNT_IDX_WIDTH-1:0];
    assign inh_hit = (csr_addr_i == MCOUNTINHIBIT_ADDR);
    assign ovf_hit = (csr_addr_i == SCOUNTOVF_ADDR);   // read only

    // --------------------------------------------------
    // write routing, applied at the same edge
    // --------------------------------------------------
    always_comb begin
        cnt_we_o = '0;
        sel_we_o = '0;
        if (csr_we_i && cnt_hit) begin
            cnt_we_o[cnt_idx] = 1'b1;
        end
        if (csr_we_i && sel_hit) begin
            sel_we_o[sel_idx] = 1'b1;
        end
    end

    assign wdata_o = csr_wdata_i;  // one data path, the target picks the view

    // 32-bit register, upper word of the csr reads zero
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            mcountinhibit_q <= '0;
        end else if (csr_we_i && inh_hit) begin
            mcountinhibit_q <= csr_wdata_i[MCOUNTINHIBIT_WIDTH-1:0];
        end
    end

    assign mcountinhibit_o = mcountinhibit_q[HPM_FIRST_CNT +: HPM_NUM_COUNTERS];

    // --------------------------------------------------
    // read mux, registered
    // --------------------------------------------------
    always_comb begin
        ovf_summary = '0;
        ovf_summary[HPM_FIRST_CNT +: HPM_NUM_COUNTERS] = ovf_bits_i;  // bit n = counter n
    end

    always_comb begin
        rd_mux = '0;                                   // unmapped reads zero
        if (cnt_hit) begin
            rd_mux = cnt_val_i[cnt_idx].cnt;
        end else if (sel_hit) begin
            rd_mux = sel_val_i[sel_idx].cnt;            // raw view of the selector
        end else if (inh_hit) begin
            rd_mux = XLEN'(mcountinhibit_q);
        end else if (ovf_hit) begin
            rd_mux = ovf_summary;
        end
    end

    // data sampled before any same-edge write lands
    always_ff @(posedge clk_i) begin
        if (csr_rd_i) begin
            rdata_q <= rd_mux;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= csr_rd_i;   // single pulse per read
        end
    end

    assign csr_rdata_o  = rdata_q;
    assign csr_rvalid_o = rvalid_q;

endmodule

`default_nettype wire

//--- hw/hpm_counter_bank.sv
// hpm counter bank
`timescale 1ns/1ps
`default_nettype none

module hpm_counter_bank
    import hpm_cfg_pkg::*;
    import hpm_event_pkg::*;
(
    input  wire logic                        clk_i,
    input  wire logic                        rstn_i,
    input  wire core_evt_t                   core_evt_i,
    input  wire mem_evt_t                    mem_evt_i,
    input  wire priv_lvl_t                   priv_lvl_i,
    input  wire logic [HPM_NUM_COUNTERS-1:0] mcountinhibit_i,
    input  wire logic [HPM_NUM_COUNTERS-1:0] cnt_we_i,
    input  wire logic [HPM_NUM_COUNTERS-1:0] sel_we_i,
    input  wire hpm_csr_word_u               wdata_i,
    output hpm_csr_word_u                    cnt_val_o [HPM_NUM_COUNTERS],
    output hpm_csr_word_u                    sel_val_o [HPM_NUM_COUNTERS],
    output logic [HPM_NUM_COUNTERS-1:0]      ovf_bits_o,
    output logic                             ovf_irq_o
);

    hpm_evt_vec_t evt_vec_d;
    hpm_evt_vec_t evt_vec_q;
    priv_lvl_t    priv_q;

    // --------------------------------------------------
    // flag structs to numbered events
    // --------------------------------------------------
    always_comb begin
        evt_vec_d[EVT_BRANCH_MISS]  = core_evt_i.branch_miss;
        evt_vec_d[EVT_IS_BRANCH]    = core_evt_i.is_branch;
        evt_vec_d[EVT_BRANCH_TAKEN] = core_evt_i.branch_taken;
        evt_vec_d[EVT_STALL_IF]     = core_evt_i.stall_if;
        evt_vec_d[EVT_STALL_ID]     = core_evt_i.stall_id;
        evt_vec_d[EVT_STALL_EXE]    = core_evt_i.stall_exe;
        evt_vec_d[EVT_LOAD_STORE]   = core_evt_i.load_store;
        evt_vec_d[EVT_DATA_DEPEND]  = core_evt_i.data_depend;
        // memory side
        evt_vec_d[EVT_ICACHE_REQ]   = mem_evt_i.icache_req;
        evt_vec_d[EVT_ICACHE_MISS]  = mem_evt_i.icache_miss;
        evt_vec_d[EVT_ITLB_MISS]    = mem_evt_i.itlb_miss;
        evt_vec_d[EVT_DTLB_MISS]    = mem_evt_i.dtlb_miss;
        evt_vec_d[EVT_DCACHE_READ]  = mem_evt_i.dcache_read;
        evt_vec_d[EVT_DCACHE_WRITE] = mem_evt_i.dcache_write;
        evt_vec_d[EVT_DCACHE_MISS]  = mem_evt_i.dcache_miss;
        evt_vec_d[EVT_DCACHE_STALL] = mem_evt_i.dcache_stall;
    end

    // one stage between the flag sources and the counters
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            evt_vec_q <= '0;
            priv_q    <= PRIV_M;
        end else begin
            evt_vec_q <= evt_vec_d;
            priv_q    <= priv_lvl_i;   // filter uses the level the events came from
        end
    end

    // --------------------------------------------------
    // counters
    // --------------------------------------------------
    for (genvar i = 0; i < HPM_NUM_COUNTERS; i++) begin : g_cnt
        hpm_counter u_counter (
            .clk_i      (clk_i),
            .rstn_i     (rstn_i),
            .evt_vec_i  (evt_vec_q),
            .priv_lvl_i (priv_q),
            .inhibit_i  (mcountinhibit_i[i]),
            .cnt_we_i   (cnt_we_i[i]),
            .sel_we_i   (sel_we_i[i]),
            .wdata_i    (wdata_i),
            .cnt_o      (cnt_val_o[i]),
            .sel_o      (sel_val_o[i]),
            .ovf_o      (ovf_bits_o[i])
        );
    end

    assign ovf_irq_o = |ovf_bits_o;  // level, drops when every sticky bit is cleared

endmodule

`default_nettype wire

//--- hw/hpm_counter.sv
// programmable event counter
`timescale 1ns/1ps
`default_nettype none

module hpm_counter
    import hpm_cfg_pkg::*;
    import hpm_event_pkg::*;
(
    input  wire logic          clk_i,
    input  wire logic          rstn_i,
    input  wire hpm_evt_vec_t  evt_vec_i,   // registered events
    input  wire priv_lvl_t     priv_lvl_i,  // registered with the events
    input  wire logic          inhibit_i,   // mcountinhibit bit of this counter
    input  wire logic          cnt_we_i,
    input  wire logic          sel_we_i,
    input  wire hpm_csr_word_u wdata_i,
    output hpm_csr_word_u      cnt_o,
    output hpm_csr_word_u      sel_o,
    output logic               ovf_o
);

    // zero padding above the top event and below event 1
    localparam int EVT_PAD = 2**EVT_SEL_WIDTH - HPM_NUM_EVENTS - 1;

    hpm_csr_word_u               cnt_q;
    hpm_csr_word_u               sel_q;
    logic [2**EVT_SEL_WIDTH-1:0] evt_ext;   // every 5-bit index hits a real bit
    logic                        evt_sel;
    logic                        priv_inh;
    logic                        inc;
    logic                        wrap;

    // --------------------------------------------------
    // event pick and filters
    // --------------------------------------------------
    assign evt_ext = {{EVT_PAD{1'b0}}, evt_vec_i, 1'b0};  // index 0 reads constant 0
    assign evt_sel = evt_ext[sel_q.sel.evt_idx];

    always_comb begin
        case (priv_lvl_i)
            PRIV_U:  priv_inh = sel_q.sel.uinh;
            PRIV_S:  priv_inh = sel_q.sel.sinh;
            PRIV_M:  priv_inh = sel_q.sel.minh;
            default: priv_inh = 1'b0;      // reserved level has no inhibit bit
        endcase
    end

    assign inc  = ~inhibit_i & evt_sel & ~priv_inh;
    assign wrap = inc & (&cnt_q.cnt) & ~cnt_we_i;  // all ones -> zero, write wins

    // --------------------------------------------------
    // state
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cnt_q <= '0;
        end else if (cnt_we_i) begin
            cnt_q <= wdata_i;              // write beats increment
        end else if (inc) begin
            cnt_q.cnt <= cnt_q.cnt + 1'b1;
        end
    end

    // selector write also clears or sets the sticky bit as written
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            sel_q <= '0;
        end else if (sel_we_i) begin
            sel_q <= wdata_i;
        end else if (wrap) begin
            sel_q.sel.ovf <= 1'b1;
        end
    end

    assign cnt_o = cnt_q;
    assign sel_o = sel_q;
    assign ovf_o = sel_q.sel.ovf;

endmodule

`default_nettype wire

//--- hw/hpm_event_pkg.sv
// hpm event sources and numbering
`default_nettype none

package hpm_event_pkg;

    // --------------------------------------------------
    // flag groups from the core and the memory system
    // --------------------------------------------------
    typedef struct packed {
        logic branch_miss;   // mispredicted branch resolved
        logic is_branch;
        logic branch_taken;
        logic stall_if;
        logic stall_id;
        logic stall_exe;
        logic load_store;    // memory op in exe
        logic data_depend;   // operand hazard
    } core_evt_t;

    typedef struct packed {
        logic icache_req;
        logic icache_miss;
        logic itlb_miss;
        logic dtlb_miss;
        logic dcache_read;
        logic dcache_write;
        logic dcache_miss;
        logic dcache_stall;
    } mem_evt_t;

    // numbered events, bit 0 does not exist (index 0 = no event)
    typedef logic [hpm_cfg_pkg::HPM_NUM_EVENTS:1] hpm_evt_vec_t;

    // event numbers as seen in a selector
    localparam int EVT_BRANCH_MISS  = 1;
    localparam int EVT_IS_BRANCH    = 2;
    localparam int EVT_BRANCH_TAKEN = 3;
    localparam int EVT_STALL_IF     = 4;
    localparam int EVT_STALL_ID     = 5;
    localparam int EVT_STALL_EXE    = 6;
    localparam int EVT_LOAD_STORE   = 7;
    localparam int EVT_DATA_DEPEND  = 8;
    localparam int EVT_ICACHE_REQ   = 9;   // memory group starts here
    localparam int EVT_ICACHE_MISS  = 10;
    localparam int EVT_ITLB_MISS    = 11;
    localparam int EVT_DTLB_MISS    = 12;
    localparam int EVT_DCACHE_READ  = 13;
    localparam int EVT_DCACHE_WRITE = 14;
    localparam int EVT_DCACHE_MISS  = 15;
    localparam int EVT_DCACHE_STALL = 16;

endpackage

`default_nettype wire

//--- hw/hpm_cfg_pkg.sv
// hpm configuration and csr map
`default_nettype none

package hpm_cfg_pkg;

    // --------------------------------------------------
    // counter bank sizes
    // --------------------------------------------------
    localparam int XLEN                = 64;
    localparam int CSR_ADDR_WIDTH      = 12;
    localparam int HPM_NUM_COUNTERS    = 8;    // arch counters 3..10
    localparam int HPM_NUM_EVENTS      = 16;
    localparam int EVT_SEL_WIDTH       = 5;    // event index field in a selector
    localparam int HPM_FIRST_CNT       = 3;    // arch number of the first programmable counter
    localparam int CNT_IDX_WIDTH       = $clog2(HPM_NUM_COUNTERS);
    localparam int MCOUNTINHIBIT_WIDTH = 32;   // one bit per arch counter

    // --------------------------------------------------
    // csr address map
    // --------------------------------------------------
    localparam logic [CSR_ADDR_WIDTH-1:0] MHPMCOUNTER_BASE   = 12'hB03;  // mhpmcounter3
    localparam logic [CSR_ADDR_WIDTH-1:0] MHPMEVENT_BASE     = 12'h323;  // mhpmevent3
    localparam logic [CSR_ADDR_WIDTH-1:0] MCOUNTINHIBIT_ADDR = 12'h320;
    localparam logic [CSR_ADDR_WIDTH-1:0] SCOUNTOVF_ADDR     = 12'hDA0;  // read only summary

    // privilege levels, 2 is reserved
    typedef logic [1:0] priv_lvl_t;

    localparam priv_lvl_t PRIV_U = 2'd0;
    localparam priv_lvl_t PRIV_S = 2'd1;
    localparam priv_lvl_t PRIV_M = 2'd3;

    // selector view of a csr word
    typedef struct packed {
        logic                         ovf;      // sticky, set on counter wrap
        logic                         minh;     // no counting in M mode
        logic                         sinh;     // no counting in S mode
        logic                         uinh;     // no counting in U mode
        logic [XLEN-EVT_SEL_WIDTH-5:0] rsvd;    // kept as written, no function
        logic [EVT_SEL_WIDTH-1:0]     evt_idx;  // 0 selects nothing
    } hpm_evt_sel_t;

    // one write word, seen as a count or as a selector
    typedef union packed {
        logic [XLEN-1:0] cnt;
        hpm_evt_sel_t    sel;
    } hpm_csr_word_u;

endpackage

`default_nettype wire
